// File: design/core_pkg.sv
package core_pkg;

	localparam int MEM_DEPTH = 256; // Words, addressed by mem_addr_t.

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [15:0] imm_t;      // Raw immediate, sign-extended at issue.
	typedef logic [7:0]  mem_addr_t;

	typedef enum logic [3:0] {
		OP_NOP,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_ADDI,
		OP_LI,
		OP_LD,
		OP_ST
	} opcode_t;

	// Source of the register write of an instruction.
	typedef enum logic [1:0] {
		WR_NONE,
		WR_IMM,
		WR_ALU,
		WR_MEM
	} wr_src_t;

	// Encoding rises with the age priority of the forwarding source.
	typedef enum logic [2:0] {
		FWD_REG,
		FWD_WB,
		FWD_MEM,
		FWD_EX_IMM,
		FWD_EX_ALU
	} fwd_sel_t;

	typedef struct packed {
		opcode_t   op;
		reg_addr_t rd;
		reg_addr_t ra;
		reg_addr_t rb;
		reg_addr_t rt;
		imm_t      imm;
	} instr_t;

	typedef struct packed {
		logic      valid;
		opcode_t   op;
		reg_addr_t rd;
		wr_src_t   wr_src;
		word_t     imm;     // Already sign-extended.
		word_t     ra_data;
		word_t     rb_data;
		word_t     rt_data;
	} ex_stage_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		wr_src_t   wr_src;
		word_t     result;
		mem_addr_t addr;
		word_t     st_data;
	} mem_stage_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		word_t     data;
	} wb_stage_t;

endpackage

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic               clk,
	input  logic               rst,
	input  core_pkg::reg_addr_t rd_addr_a,
	input  core_pkg::reg_addr_t rd_addr_b,
	input  core_pkg::reg_addr_t rd_addr_t,
	output core_pkg::word_t     rd_data_a,
	output core_pkg::word_t     rd_data_b,
	output core_pkg::word_t     rd_data_t,
	input  logic               wr_en,
	input  core_pkg::reg_addr_t wr_addr,
	input  core_pkg::word_t     wr_data
);

	core_pkg::word_t regs [0:31];

	// No read bypass here. A value being written this cycle is still in
	// writeback and reaches the reader through the forwarding network.
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];
	assign rd_data_t = regs[rd_addr_t];

	always_ff @(posedge clk) begin
		if (wr_en && !rst) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// The stage valid bits are cleared by reset, so the writeback port
	// must be quiet on the cycle that follows a reset edge.
	a_no_write_after_rst: assert property (
		@(posedge clk) rst |=> !wr_en
	) else $error("register write right after reset");

endmodule

// File: design/fwd_select.sv
`timescale 1ns/1ps

module fwd_select (
	input  core_pkg::reg_addr_t  src_addr,
	input  core_pkg::word_t      src_data,
	input  core_pkg::ex_stage_t  ex,
	input  core_pkg::word_t      ex_result,
	input  core_pkg::mem_stage_t mem,
	input  core_pkg::word_t      mem_rd_data,
	input  core_pkg::wb_stage_t  wb_in,
	output core_pkg::fwd_sel_t   sel,
	output core_pkg::word_t      data
);

	logic            ex_hit;
	logic            mem_hit;
	logic            wb_hit;
	core_pkg::word_t mem_wr_data;

	assign ex_hit  = ex.valid && (ex.rd == src_addr);
	assign mem_hit = mem.valid && (mem.wr_src != core_pkg::WR_NONE) && (mem.rd == src_addr);
	assign wb_hit  = wb_in.valid && (wb_in.rd == src_addr); // wb only carries writes.

	// A load in memory hands over the word it is reading right now.
	assign mem_wr_data = (mem.wr_src == core_pkg::WR_MEM) ? mem_rd_data : mem.result;

	// Later checks override earlier ones, so the youngest stage wins.
	always_comb begin
		sel = core_pkg::FWD_REG;
		if (wb_hit) begin
			sel = core_pkg::FWD_WB;
		end
		if (mem_hit) begin
			sel = core_pkg::FWD_MEM;
		end
		if (ex_hit) begin
			// A load in execute has no data yet; the hazard logic stalls issue.
			if (ex.wr_src == core_pkg::WR_IMM) begin
				sel = core_pkg::FWD_EX_IMM;
			end else if (ex.wr_src == core_pkg::WR_ALU) begin
				sel = core_pkg::FWD_EX_ALU;
			end
		end
	end

	always_comb begin
		case (sel)
			core_pkg::FWD_WB:     data = wb_in.data;
			core_pkg::FWD_MEM:    data = mem_wr_data;
			core_pkg::FWD_EX_IMM: data = ex.imm;
			core_pkg::FWD_EX_ALU: data = ex_result;
			default:              data = src_data;
		endcase
	end

endmodule

// File: design/forward.sv
`timescale 1ns/1ps

module forward (
	input  core_pkg::reg_addr_t  src_a,
	input  core_pkg::reg_addr_t  src_b,
	input  core_pkg::reg_addr_t  src_t,
	input  core_pkg::word_t      reg_a,
	input  core_pkg::word_t      reg_b,
	input  core_pkg::word_t      reg_t,
	input  logic                 issue_is_store,
	input  core_pkg::ex_stage_t  ex,
	input  core_pkg::word_t      ex_result,
	input  core_pkg::mem_stage_t mem,
	input  core_pkg::word_t      mem_rd_data,
	input  core_pkg::wb_stage_t  wb_in,
	output core_pkg::word_t      fwd_a,
	output core_pkg::word_t      fwd_b,
	output core_pkg::word_t      fwd_t,
	output logic                 load_hazard
);

	core_pkg::fwd_sel_t sel_a;
	core_pkg::fwd_sel_t sel_b;
	core_pkg::fwd_sel_t sel_t;
	logic               ex_is_load;
	logic               ex_picked;

	fwd_select fwd_a_inst (
		.src_addr(src_a), .src_data(reg_a),
		.ex(ex), .ex_result(ex_result),
		.mem(mem), .mem_rd_data(mem_rd_data),
		.wb_in(wb_in),
		.sel(sel_a), .data(fwd_a)
	);

	fwd_select fwd_b_inst (
		.src_addr(src_b), .src_data(reg_b),
		.ex(ex), .ex_result(ex_result),
		.mem(mem), .mem_rd_data(mem_rd_data),
		.wb_in(wb_in),
		.sel(sel_b), .data(fwd_b)
	);

	fwd_select fwd_t_inst (
		.src_addr(src_t), .src_data(reg_t),
		.ex(ex), .ex_result(ex_result),
		.mem(mem), .mem_rd_data(mem_rd_data),
		.wb_in(wb_in),
		.sel(sel_t), .data(fwd_t)
	);

	assign ex_is_load = ex.valid && (ex.wr_src == core_pkg::WR_MEM);

	// Store data is only a source for a store; other ops ignore rt.
	assign load_hazard = ex_is_load &&
		((src_a == ex.rd) || (src_b == ex.rd) || (issue_is_store && (src_t == ex.rd)));

	assign ex_picked = (sel_a inside {core_pkg::FWD_EX_IMM, core_pkg::FWD_EX_ALU}) ||
		(sel_b inside {core_pkg::FWD_EX_IMM, core_pkg::FWD_EX_ALU}) ||
		(sel_t inside {core_pkg::FWD_EX_IMM, core_pkg::FWD_EX_ALU});

	// A hazard means a decoded load sits in execute, and no operand may
	// then have taken its value from the execute stage.
	always_comb begin
		assert final (!load_hazard || (ex.valid && ex.op == core_pkg::OP_LD && !ex_picked))
			else $error("load hazard without a clean load in execute");
	end

endmodule

// File: design/alu.sv
`timescale 1ns/1ps

module alu (
	input  core_pkg::opcode_t   op,
	input  core_pkg::word_t     a,
	input  core_pkg::word_t     b,
	input  core_pkg::word_t     imm,
	output core_pkg::word_t     result,
	output core_pkg::mem_addr_t mem_addr
);

	core_pkg::word_t addr_sum;

	assign addr_sum = a + imm; // Shared by addi and the load/store address.

	always_comb begin
		case (op)
			core_pkg::OP_ADD: begin
				result = a + b;
			end
			core_pkg::OP_SUB: begin
				result = a - b;
			end
			core_pkg::OP_AND: begin
				result = a & b;
			end
			core_pkg::OP_OR: begin
				result = a | b;
			end
			core_pkg::OP_XOR: begin
				result = a ^ b;
			end
			default: begin
				result = addr_sum; // addi; ld and st ignore it.
			end
		endcase
	end

	// Data memory is word addressed and wraps at its depth.
	assign mem_addr = addr_sum[7:0];

endmodule

// File: design/data_mem.sv
`timescale 1ns/1ps

module data_mem (
	input  logic                clk,
	input  core_pkg::mem_addr_t mem_addr,
	input  logic                st_en,
	input  core_pkg::word_t     st_data,
	output core_pkg::word_t     rd_data
);

	core_pkg::word_t mem [0:core_pkg::MEM_DEPTH-1];

	always_ff @(posedge clk) begin
		if (st_en) begin
			mem[mem_addr] <= st_data;
		end
	end

	// The load result is needed in the same cycle for forwarding.
	assign rd_data = mem[mem_addr];

endmodule

// File: design/exec_pipe.sv
`timescale 1ns/1ps

module exec_pipe (
	input  logic                clk,
	input  logic                rst,
	input  logic                instr_valid,
	input  core_pkg::instr_t    instr,
	output logic                instr_hold,
	output core_pkg::wb_stage_t wb
);

	core_pkg::ex_stage_t  ex_stage;
	core_pkg::mem_stage_t mem_stage;
	core_pkg::wr_src_t    issue_wr_src;
	core_pkg::word_t      issue_imm;
	core_pkg::word_t      reg_a, reg_b, reg_t;
	core_pkg::word_t      fwd_a, fwd_b, fwd_t;
	core_pkg::word_t      alu_result;
	core_pkg::mem_addr_t  alu_addr;
	core_pkg::word_t      mem_rd_data;
	logic                 load_hazard;
	logic                 accept;
	logic                 st_en;

	always_comb begin
		case (instr.op)
			core_pkg::OP_ADD, core_pkg::OP_SUB, core_pkg::OP_AND,
			core_pkg::OP_OR, core_pkg::OP_XOR, core_pkg::OP_ADDI: issue_wr_src = core_pkg::WR_ALU;
			core_pkg::OP_LI: issue_wr_src = core_pkg::WR_IMM;
			core_pkg::OP_LD: issue_wr_src = core_pkg::WR_MEM;
			default:         issue_wr_src = core_pkg::WR_NONE;
		endcase
	end

	assign issue_imm  = {{16{instr.imm[15]}}, instr.imm};
	assign instr_hold = instr_valid && load_hazard;
	assign accept     = instr_valid && !load_hazard;

	reg_file reg_file_inst (
		.clk(clk), .rst(rst),
		.rd_addr_a(instr.ra), .rd_addr_b(instr.rb), .rd_addr_t(instr.rt),
		.rd_data_a(reg_a), .rd_data_b(reg_b), .rd_data_t(reg_t),
		.wr_en(wb.valid), .wr_addr(wb.rd), .wr_data(wb.data)
	);

	forward forward_inst (
		.src_a(instr.ra), .src_b(instr.rb), .src_t(instr.rt),
		.reg_a(reg_a), .reg_b(reg_b), .reg_t(reg_t),
		.issue_is_store(instr.op == core_pkg::OP_ST),
		.ex(ex_stage), .ex_result(alu_result),
		.mem(mem_stage), .mem_rd_data(mem_rd_data),
		.wb_in(wb),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .fwd_t(fwd_t),
		.load_hazard(load_hazard)
	);

	alu alu_inst (
		.op(ex_stage.op), .a(ex_stage.ra_data), .b(ex_stage.rb_data), .imm(ex_stage.imm),
		.result(alu_result), .mem_addr(alu_addr)
	);

	// Nops never get a valid bit, so a valid memory-stage entry without a
	// register write can only be a store.
	assign st_en = mem_stage.valid && (mem_stage.wr_src == core_pkg::WR_NONE);

	data_mem data_mem_inst (
		.clk(clk), .mem_addr(mem_stage.addr),
		.st_en(st_en), .st_data(mem_stage.st_data),
		.rd_data(mem_rd_data)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_stage.valid  <= 1'b0;
			mem_stage.valid <= 1'b0;
			wb.valid        <= 1'b0;
		end else begin
			ex_stage.valid  <= accept && (instr.op != core_pkg::OP_NOP); // Bubble on hold.
			mem_stage.valid <= ex_stage.valid;
			wb.valid        <= mem_stage.valid && (mem_stage.wr_src != core_pkg::WR_NONE);
		end
	end

	always_ff @(posedge clk) begin
		ex_stage.op      <= instr.op;
		ex_stage.rd      <= instr.rd;
		ex_stage.wr_src  <= issue_wr_src;
		ex_stage.imm     <= issue_imm;
		ex_stage.ra_data <= fwd_a;
		ex_stage.rb_data <= fwd_b;
		ex_stage.rt_data <= fwd_t;

		mem_stage.rd      <= ex_stage.rd;
		mem_stage.wr_src  <= ex_stage.wr_src;
		mem_stage.result  <= (ex_stage.wr_src == core_pkg::WR_IMM) ? ex_stage.imm : alu_result;
		mem_stage.addr    <= alu_addr;
		mem_stage.st_data <= ex_stage.rt_data;

		wb.rd   <= mem_stage.rd;
		wb.data <= (mem_stage.wr_src == core_pkg::WR_MEM) ? mem_rd_data : mem_stage.result;
	end

	a_wb_valid_known: assert property (
		@(posedge clk) disable iff (rst) !$isunknown(wb.valid)
	) else $error("wb.valid is unknown");

endmodule

// File: verif/tb_vectors.svh
// Columns are op, rd, ra, rb, rt, imm, tight and the expected write data.
// A tight entry is followed by the next one with no idle cycle in between.

localparam int EXPECTED_HOLDS = 4; // Every load is directly followed by a reader.

task automatic load_vectors();
	// Independent li and ALU operations.
	add_vec(core_pkg::OP_LI,   5'd1,  5'd0,  5'd0, 5'd0,  16'h0005, 1'b0, 32'h0000_0005);
	add_vec(core_pkg::OP_LI,   5'd2,  5'd0,  5'd0, 5'd0,  16'h0003, 1'b0, 32'h0000_0003);
	add_vec(core_pkg::OP_LI,   5'd3,  5'd0,  5'd0, 5'd0,  16'hFFF0, 1'b0, 32'hFFFF_FFF0);
	add_vec(core_pkg::OP_LI,   5'd4,  5'd0,  5'd0, 5'd0,  16'h00FF, 1'b0, 32'h0000_00FF);
	add_vec(core_pkg::OP_ADD,  5'd5,  5'd1,  5'd2, 5'd0,  16'h0000, 1'b0, 32'h0000_0008);
	add_vec(core_pkg::OP_SUB,  5'd6,  5'd1,  5'd2, 5'd0,  16'h0000, 1'b0, 32'h0000_0002);
	add_vec(core_pkg::OP_AND,  5'd7,  5'd3,  5'd4, 5'd0,  16'h0000, 1'b0, 32'h0000_00F0);
	add_vec(core_pkg::OP_OR,   5'd8,  5'd3,  5'd4, 5'd0,  16'h0000, 1'b0, 32'hFFFF_FFFF);
	add_vec(core_pkg::OP_XOR,  5'd9,  5'd3,  5'd4, 5'd0,  16'h0000, 1'b0, 32'hFFFF_FF0F);
	add_vec(core_pkg::OP_ADDI, 5'd10, 5'd1,  5'd0, 5'd0,  16'hFFFF, 1'b0, 32'h0000_0004);

	// Chains through the execute stage, immediate first and then ALU result.
	add_vec(core_pkg::OP_LI,   5'd11, 5'd0,  5'd0, 5'd0,  16'h0010, 1'b1, 32'h0000_0010);
	add_vec(core_pkg::OP_ADDI, 5'd12, 5'd11, 5'd0, 5'd0,  16'h0001, 1'b1, 32'h0000_0011);
	add_vec(core_pkg::OP_ADD,  5'd13, 5'd12, 5'd11, 5'd0, 16'h0000, 1'b1, 32'h0000_0021);
	add_vec(core_pkg::OP_SUB,  5'd14, 5'd13, 5'd12, 5'd0, 16'h0000, 1'b0, 32'h0000_0010);
	add_vec(core_pkg::OP_XOR,  5'd15, 5'd14, 5'd13, 5'd0, 16'h0000, 1'b0, 32'h0000_0031);

	// Nops push the producer into memory, then into writeback.
	add_vec(core_pkg::OP_LI,   5'd16, 5'd0,  5'd0, 5'd0,  16'h0100, 1'b1, 32'h0000_0100);
	add_vec(core_pkg::OP_NOP,  5'd0,  5'd0,  5'd0, 5'd0,  16'h0000, 1'b1, 32'h0000_0000);
	add_vec(core_pkg::OP_ADDI, 5'd17, 5'd16, 5'd0, 5'd0,  16'h0002, 1'b1, 32'h0000_0102);
	add_vec(core_pkg::OP_NOP,  5'd0,  5'd0,  5'd0, 5'd0,  16'h0000, 1'b1, 32'h0000_0000);
	add_vec(core_pkg::OP_NOP,  5'd0,  5'd0,  5'd0, 5'd0,  16'h0000, 1'b1, 32'h0000_0000);
	add_vec(core_pkg::OP_ADD,  5'd18, 5'd17, 5'd16, 5'd0, 16'h0000, 1'b0, 32'h0000_0202);

	// Store then load of the same word, and load-use stalls.
	add_vec(core_pkg::OP_LI,   5'd20, 5'd0,  5'd0, 5'd0,  16'h0040, 1'b0, 32'h0000_0040);
	add_vec(core_pkg::OP_LI,   5'd21, 5'd0,  5'd0, 5'd0,  16'h7ABC, 1'b1, 32'h0000_7ABC);
	add_vec(core_pkg::OP_ST,   5'd0,  5'd20, 5'd0, 5'd21, 16'h0002, 1'b1, 32'h0000_0000);
	add_vec(core_pkg::OP_LD,   5'd22, 5'd20, 5'd0, 5'd0,  16'h0002, 1'b1, 32'h0000_7ABC);
	add_vec(core_pkg::OP_ADD,  5'd23, 5'd22, 5'd1, 5'd0,  16'h0000, 1'b0, 32'h0000_7AC1);
	add_vec(core_pkg::OP_LD,   5'd24, 5'd20, 5'd0, 5'd0,  16'h0002, 1'b1, 32'h0000_7ABC);
	add_vec(core_pkg::OP_ST,   5'd0,  5'd20, 5'd0, 5'd24, 16'h0005, 1'b1, 32'h0000_0000);
	add_vec(core_pkg::OP_LD,   5'd25, 5'd20, 5'd0, 5'd0,  16'h0005, 1'b1, 32'h0000_7ABC);
	add_vec(core_pkg::OP_SUB,  5'd26, 5'd25, 5'd23, 5'd0, 16'h0000, 1'b0, 32'hFFFF_FFFB);
	add_vec(core_pkg::OP_ADDI, 5'd27, 5'd21, 5'd0, 5'd0,  16'h0001, 1'b1, 32'h0000_7ABD);
	add_vec(core_pkg::OP_ST,   5'd0,  5'd20, 5'd0, 5'd27, 16'h0003, 1'b1, 32'h0000_0000);
	add_vec(core_pkg::OP_LD,   5'd28, 5'd20, 5'd0, 5'd0,  16'h0003, 1'b1, 32'h0000_7ABD);
	add_vec(core_pkg::OP_OR,   5'd29, 5'd28, 5'd2, 5'd0,  16'h0000, 1'b0, 32'h0000_7ABF);

	// Rewrites of r30, the youngest value must win.
	add_vec(core_pkg::OP_LI,   5'd30, 5'd0,  5'd0, 5'd0,  16'h0001, 1'b1, 32'h0000_0001);
	add_vec(core_pkg::OP_LI,   5'd30, 5'd0,  5'd0, 5'd0,  16'h0002, 1'b1, 32'h0000_0002);
	add_vec(core_pkg::OP_ADDI, 5'd31, 5'd30, 5'd0, 5'd0,  16'h0000, 1'b1, 32'h0000_0002);
	add_vec(core_pkg::OP_ADD,  5'd30, 5'd30, 5'd30, 5'd0, 16'h0000, 1'b0, 32'h0000_0004);
	add_vec(core_pkg::OP_LI,   5'd30, 5'd0,  5'd0, 5'd0,  16'h0009, 1'b0, 32'h0000_0009);
	add_vec(core_pkg::OP_NOP,  5'd0,  5'd0,  5'd0, 5'd0,  16'h0000, 1'b0, 32'h0000_0000);
	add_vec(core_pkg::OP_XOR,  5'd19, 5'd30, 5'd31, 5'd0, 16'h0000, 1'b0, 32'h0000_000B);
endtask

// File: verif/exec_pipe_tb.sv
`timescale 1ns/1ps

module exec_pipe_tb;

	localparam int HOLD_TIMEOUT = 10; // Cycles one instruction may stay held.
	localparam int WB_TIMEOUT   = 50;

	typedef struct packed {
		core_pkg::instr_t ins;
		logic             tight;    // Next entry follows with no idle cycle.
		logic             writes;
		core_pkg::word_t  exp_data;
	} vec_t;

	logic                clk;
	logic                rst;
	logic                instr_valid;
	core_pkg::instr_t    instr;
	logic                instr_hold;
	core_pkg::wb_stage_t wb;

	vec_t        program_q[$];
	int          hold_cycles;
	logic [31:0] rng_state;

	exec_pipe exec_pipe_inst (
		.clk(clk),
		.rst(rst),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_hold(instr_hold),
		.wb(wb)
	);

	`include "tb_vectors.svh"

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic stop_run();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic give_up(input string why);
		$display("%s", why);
		stop_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected);
			stop_run();
		end
	endtask

	task automatic add_vec(
		input core_pkg::opcode_t   op,
		input core_pkg::reg_addr_t rd,
		input core_pkg::reg_addr_t ra,
		input core_pkg::reg_addr_t rb,
		input core_pkg::reg_addr_t rt,
		input core_pkg::imm_t      imm,
		input logic                tight,
		input core_pkg::word_t     exp_data
	);
		vec_t v;
		v.ins.op   = op;
		v.ins.rd   = rd;
		v.ins.ra   = ra;
		v.ins.rb   = rb;
		v.ins.rt   = rt;
		v.ins.imm  = imm;
		v.tight    = tight;
		v.writes   = !(op inside {core_pkg::OP_NOP, core_pkg::OP_ST}); // No wb for these.
		v.exp_data = exp_data;
		program_q.push_back(v);
	endtask

	// Presents each entry, waits out any hold, then idles for a random gap.
	task automatic drive_program();
		int waited;
		int gap;
		foreach (program_q[i]) begin
			@(posedge clk);
			instr_valid <= 1'b1;
			instr       <= program_q[i].ins;
			waited = 0;
			@(negedge clk);
			while (instr_hold) begin
				hold_cycles++;
				waited++;
				if (waited > HOLD_TIMEOUT) begin
					give_up($sformatf("instruction %0d was held too long", i));
				end
				@(negedge clk);
			end
			gap = 0;
			if (!program_q[i].tight) begin
				rng_state = next_random(rng_state);
				gap = int'(rng_state[1:0]);
			end
			repeat (gap) begin
				@(posedge clk);
				instr_valid <= 1'b0;
			end
		end
		@(posedge clk);
		instr_valid <= 1'b0;
	endtask

	task automatic collect_writebacks();
		int waited;
		foreach (program_q[i]) begin
			if (program_q[i].writes) begin
				waited = 0;
				@(negedge clk);
				while (!wb.valid) begin
					waited++;
					if (waited > WB_TIMEOUT) begin
						give_up($sformatf("no writeback arrived for entry %0d", i));
					end
					@(negedge clk);
				end
				check_value("wb.rd", 32'(wb.rd), 32'(program_q[i].ins.rd));
				check_value("wb.data", wb.data, program_q[i].exp_data);
			end
		end
	endtask

	initial begin
		rst         = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		hold_cycles = 0;
		rng_state   = 32'd88099;
		load_vectors();
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// The pipeline must stay quiet until the first instruction.
		repeat (3) begin
			@(negedge clk);
			check_value("wb.valid", 32'(wb.valid), 32'd0);
			check_value("instr_hold", 32'(instr_hold), 32'd0);
		end

		fork
			drive_program();
			collect_writebacks();
		join

		check_value("hold_cycles", 32'(hold_cycles), 32'(EXPECTED_HOLDS));
		$display("TEST OK");
		$finish;
	end

endmodule

// File: flist.f
+incdir+verif
design/core_pkg.sv
design/reg_file.sv
design/fwd_select.sv
design/forward.sv
design/alu.sv
design/data_mem.sv
design/exec_pipe.sv
verif/exec_pipe_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= exec_pipe_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
